//--- src/spi_hub_settings.svh
`ifndef SPI_HUB_SETTINGS_SVH
`define SPI_HUB_SETTINGS_SVH

// ------------------------------
// bus and lane widths
// ------------------------------
`define SPI_HUB_ADDR_W     12       // io bus address
`define SPI_HUB_DATA_W     16       // io bus data word
`define SPI_HUB_OFS_W      4        // offset bits inside a channel window
`define SPI_HUB_LANES      4        // dq3..dq0
`define SPI_HUB_CNT_W      5        // transfer counter

// ------------------------------
// channel windows
// ------------------------------
`define SPI_HUB_FLASH_BASE 12'h110
`define SPI_HUB_GFX_BASE   12'h100

`define SPI_OFS_PINS       4'd0     // wr manual pins, rd lane inputs
`define SPI_OFS_START8     4'd1     // wr start 8-bit, rd rx word
`define SPI_OFS_START16    4'd2     // wr start 16-bit, rd rx word
`define SPI_OFS_IDLE       4'd3     // rd idle bit
`define SPI_OFS_DIR        4'd4     // wr direction bit
`define SPI_OFS_QUAD       4'd5     // wr quad-mode bit

// counter stepping
`define SPI_STEP_SINGLE    1
`define SPI_STEP_QUAD      4
`define SPI_START8_COUNT   16       // half the counter range for 8 bits

`endif

//--- src/spi_io_pkg.sv
`include "spi_hub_settings.svh"

// bus side of the hub: addresses, data and window offsets
package spi_io_pkg;

  // ------------------------------
  // io bus
  // ------------------------------
  typedef logic [`SPI_HUB_ADDR_W-1:0] io_addr_t;  // full io address

  // bus data word, also the width of the channel shifter
  typedef logic [`SPI_HUB_DATA_W-1:0] io_word_t;

  // ------------------------------
  // register window
  // ------------------------------
  typedef logic [`SPI_HUB_OFS_W-1:0] reg_ofs_t;   // offset from channel base

endpackage

//--- src/spi_line_pkg.sv
`include "spi_hub_settings.svh"

// pin side of a channel
package spi_line_pkg;

  typedef logic [`SPI_HUB_LANES-1:0] lane_t;      // dq3..dq0

  // bit order matches the manual pin register: cs, sck, dq3..dq0
  typedef struct packed {
    logic  cs;
    logic  sck;
    lane_t lanes;
  } spi_pins_t;

  // ------------------------------
  // engine
  // ------------------------------
  typedef logic [`SPI_HUB_CNT_W-1:0] step_cnt_t;  // wraps to 0 at end of transfer

endpackage

//--- src/spi_ctrl_if.sv
`timescale 1ns/1ps

// control and status between the register block and one channel
interface spi_ctrl_if;

  // ------------------------------
  // from the register block
  // ------------------------------
  logic                   start8;   // one-cycle, 8-bit transfer
  logic                   start16;  // one-cycle, 16-bit transfer
  spi_io_pkg::io_word_t   tx;       // bus write word
  spi_line_pkg::spi_pins_t manual;  // manual pin register
  logic                   dir;      // quad lanes are inputs when set
  logic                   quad;     // four lanes instead of one

  // ------------------------------
  // from the channel
  // ------------------------------
  spi_io_pkg::io_word_t   rx;       // shifter contents
  logic                   idle;

  modport regs (
    output start8, start16, tx, manual, dir, quad,
    input  rx, idle
  );

  modport chan (
    input  start8, start16, tx, manual, dir, quad,
    output rx, idle
  );

endinterface

//--- src/spi_io_regs.sv
`timescale 1ns/1ps
`include "spi_hub_settings.svh"

module spi_io_regs (
  input  logic                    pclk,
  input  logic                    SCKclock,
  input  spi_io_pkg::io_addr_t    io_a_i,
  input  spi_io_pkg::io_word_t    io_wd_i,
  input  logic                    io_w_i,
  output spi_io_pkg::io_word_t    io_rd_o,
  input  spi_line_pkg::lane_t     flash_dq_i,
  input  spi_line_pkg::lane_t     gfx_dq_i,
  spi_ctrl_if.regs                flash_ctrl,
  spi_ctrl_if.regs                gfx_ctrl
);

  localparam int N_CH = 2;  // 0 flash, 1 gfx
  localparam int WIN_LSB = `SPI_HUB_OFS_W;
  localparam spi_io_pkg::io_addr_t CH_BASE [N_CH] = '{`SPI_HUB_FLASH_BASE, `SPI_HUB_GFX_BASE};

  spi_io_pkg::reg_ofs_t     ofs;
  logic [N_CH-1:0]          hit;
  logic [N_CH-1:0]          wr_en;
  logic [N_CH-1:0]          start8;
  logic [N_CH-1:0]          start16;
  spi_line_pkg::spi_pins_t  manual_q [N_CH];
  logic [N_CH-1:0]          dir_q;
  logic [N_CH-1:0]          quad_q;
  spi_line_pkg::lane_t      lanes_in [N_CH];
  spi_io_pkg::io_word_t     rx_word [N_CH];
  logic [N_CH-1:0]          idle;

  assign ofs = io_a_i[WIN_LSB-1:0];

  // ------------------------------
  // address decode
  // ------------------------------
  always_comb begin
    for (int c = 0; c < N_CH; c++) begin
      hit[c]     = (io_a_i[`SPI_HUB_ADDR_W-1:WIN_LSB] == CH_BASE[c][`SPI_HUB_ADDR_W-1:WIN_LSB]);
      wr_en[c]   = io_w_i & hit[c];
      start8[c]  = wr_en[c] & (ofs == `SPI_OFS_START8);   // engine loads at this edge
      start16[c] = wr_en[c] & (ofs == `SPI_OFS_START16);
    end
  end

  // ------------------------------
  // configuration registers
  // ------------------------------
  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      for (int c = 0; c < N_CH; c++) begin
        manual_q[c] <= '0;
        dir_q[c]    <= 1'b0;
        quad_q[c]   <= 1'b0;
      end
    end else begin
      for (int c = 0; c < N_CH; c++) begin
        if (wr_en[c]) begin
          case (ofs)
            `SPI_OFS_PINS: manual_q[c] <= spi_line_pkg::spi_pins_t'(io_wd_i[5:0]);
            `SPI_OFS_DIR:  dir_q[c]    <= io_wd_i[0];
            `SPI_OFS_QUAD: quad_q[c]   <= io_wd_i[0];
            default: ;                                      // starts are strobes only
          endcase
        end
      end
    end
  end

  // channel status into arrays
  assign lanes_in[0] = flash_dq_i;
  assign lanes_in[1] = gfx_dq_i;
  assign rx_word[0]  = flash_ctrl.rx;
  assign rx_word[1]  = gfx_ctrl.rx;
  assign idle[0]     = flash_ctrl.idle;
  assign idle[1]     = gfx_ctrl.idle;

  // ------------------------------
  // read data, zero for unmapped
  // ------------------------------
  always_comb begin
    io_rd_o = '0;
    for (int c = 0; c < N_CH; c++) begin
      if (hit[c]) begin
        case (ofs)
          `SPI_OFS_PINS:    io_rd_o = spi_io_pkg::io_word_t'(lanes_in[c]);
          `SPI_OFS_START8,
          `SPI_OFS_START16: io_rd_o = rx_word[c];
          `SPI_OFS_IDLE:    io_rd_o = spi_io_pkg::io_word_t'(idle[c]);
          default:          io_rd_o = '0;             // dir and quad are write only
        endcase
      end
    end
  end

  // ------------------------------
  // control out to the channels
  // ------------------------------
  assign flash_ctrl.start8  = start8[0];
  assign flash_ctrl.start16 = start16[0];
  assign flash_ctrl.tx      = io_wd_i;
  assign flash_ctrl.manual  = manual_q[0];
  assign flash_ctrl.dir     = dir_q[0];
  assign flash_ctrl.quad    = quad_q[0];

  assign gfx_ctrl.start8    = start8[1];
  assign gfx_ctrl.start16   = start16[1];
  assign gfx_ctrl.tx        = io_wd_i;
  assign gfx_ctrl.manual    = manual_q[1];
  assign gfx_ctrl.dir       = dir_q[1];
  assign gfx_ctrl.quad      = quad_q[1];

  // strobes seen by the channels come only from bus writes
  a_start_needs_write: assert property (
    @(posedge pclk) disable iff (SCKclock)
    (flash_ctrl.start8 | flash_ctrl.start16 | gfx_ctrl.start8 | gfx_ctrl.start16) |-> io_w_i
  );

  a_start_exclusive: assert property (
    @(posedge pclk) disable iff (SCKclock)
    !(flash_ctrl.start8 & flash_ctrl.start16) && !(gfx_ctrl.start8 & gfx_ctrl.start16)
  );

endmodule

//--- src/spi_channel.sv
`timescale 1ns/1ps
`include "spi_hub_settings.svh"

module spi_channel (
  input  logic                 pclk,
  input  logic                 SCKclock,
  spi_ctrl_if.chan             ctrl,
  output logic                 cs_o,
  output logic                 sck_o,
  output spi_line_pkg::lane_t  dq_o,
  output spi_line_pkg::lane_t  dq_oe_o,
  input  spi_line_pkg::lane_t  dq_i
);

  logic                     running_q;
  spi_line_pkg::step_cnt_t  count_q;
  spi_line_pkg::step_cnt_t  count_nxt;
  spi_line_pkg::step_cnt_t  step;
  spi_io_pkg::io_word_t     shift_q;
  spi_io_pkg::io_word_t     tx_swap;
  logic                     sclk;
  logic                     start;
  spi_line_pkg::spi_pins_t  eng_pins;
  spi_line_pkg::spi_pins_t  pins;
  spi_line_pkg::lane_t      lane_mask;

  assign start   = ctrl.start8 | ctrl.start16;
  assign tx_swap = {ctrl.tx[7:0], ctrl.tx[15:8]};     // first byte goes out first
  assign step    = ctrl.quad ? spi_line_pkg::step_cnt_t'(`SPI_STEP_QUAD)
                             : spi_line_pkg::step_cnt_t'(`SPI_STEP_SINGLE);
  assign count_nxt = count_q + step;
  assign sclk      = ctrl.quad ? count_q[2] : count_q[0];

  // ------------------------------
  // shift engine
  // ------------------------------
  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      running_q <= 1'b0;
      count_q   <= '0;
      shift_q   <= '0;
    end else if (start) begin                          // restart allowed while busy
      running_q <= 1'b1;
      count_q   <= ctrl.start8 ? spi_line_pkg::step_cnt_t'(`SPI_START8_COUNT) : '0;
      shift_q   <= tx_swap;
    end else if (running_q) begin
      running_q <= (count_nxt != '0);                  // done on wrap
      count_q   <= count_nxt;
      if (sclk) begin
        shift_q <= ctrl.quad ? {shift_q[11:0], dq_i}   // sample on high sck
                             : {shift_q[14:0], dq_i[1]};
      end
    end
  end

  assign ctrl.rx   = shift_q;
  assign ctrl.idle = ~running_q;

  // ------------------------------
  // pins and lane mask
  // ------------------------------
  always_comb begin
    eng_pins.cs    = 1'b0;                             // cs is software driven
    eng_pins.sck   = sclk;
    eng_pins.lanes = ctrl.quad ? shift_q[15:12] : {3'b000, shift_q[15]};
  end

  assign pins = spi_line_pkg::spi_pins_t'(ctrl.manual | eng_pins);

  // mask bit set means the lane is an input
  assign lane_mask = ctrl.quad ? {`SPI_HUB_LANES{ctrl.dir}} : 4'b0010;

  assign cs_o    = pins.cs;
  assign sck_o   = pins.sck;
  assign dq_o    = pins.lanes;
  assign dq_oe_o = ~lane_mask;

  // register block sees busy on the read after its start write
  a_busy_after_start: assert property (
    @(posedge pclk) disable iff (SCKclock)
    start |=> !ctrl.idle
  );

  a_count_holds_idle: assert property (
    @(posedge pclk) disable iff (SCKclock)
    (ctrl.idle && !start) |=> $stable(count_q)
  );

endmodule

//--- src/spi_io_hub.sv
`timescale 1ns/1ps

module spi_io_hub (
  input  logic                    pclk,
  input  logic                    SCKclock,

  // io bus
  input  spi_io_pkg::io_addr_t    io_a_i,
  input  spi_io_pkg::io_word_t    io_wd_i,
  input  logic                    io_w_i,
  output spi_io_pkg::io_word_t    io_rd_o,

  // flash channel
  output logic                    flash_cs_o,
  output logic                    flash_sck_o,
  output spi_line_pkg::lane_t     flash_dq_o,
  output spi_line_pkg::lane_t     flash_dq_oe_o,
  input  spi_line_pkg::lane_t     flash_dq_i,

  // graphics-chip channel
  output logic                    gfx_cs_o,
  output logic                    gfx_sck_o,
  output spi_line_pkg::lane_t     gfx_dq_o,
  output spi_line_pkg::lane_t     gfx_dq_oe_o,
  input  spi_line_pkg::lane_t     gfx_dq_i
);

  spi_ctrl_if flash_if ();
  spi_ctrl_if gfx_if ();

  // ------------------------------
  // register map
  // ------------------------------
  spi_io_regs u_regs (
    .pclk        (pclk),
    .SCKclock    (SCKclock),
    .io_a_i      (io_a_i),
    .io_wd_i     (io_wd_i),
    .io_w_i      (io_w_i),
    .io_rd_o     (io_rd_o),
    .flash_dq_i  (flash_dq_i),
    .gfx_dq_i    (gfx_dq_i),
    .flash_ctrl  (flash_if.regs),
    .gfx_ctrl    (gfx_if.regs)
  );

  // ------------------------------
  // channels
  // ------------------------------
  spi_channel u_flash (
    .pclk        (pclk),
    .SCKclock    (SCKclock),
    .ctrl        (flash_if.chan),
    .cs_o        (flash_cs_o),
    .sck_o       (flash_sck_o),
    .dq_o        (flash_dq_o),
    .dq_oe_o     (flash_dq_oe_o),
    .dq_i        (flash_dq_i)
  );

  spi_channel u_gfx (
    .pclk        (pclk),
    .SCKclock    (SCKclock),
    .ctrl        (gfx_if.chan),
    .cs_o        (gfx_cs_o),
    .sck_o       (gfx_sck_o),
    .dq_o        (gfx_dq_o),
    .dq_oe_o     (gfx_dq_oe_o),
    .dq_i        (gfx_dq_i)
  );

endmodule

//--- test/tb_spi_io_hub.sv
`timescale 1ns/1ps
`include "spi_hub_settings.svh"

module tb_spi_io_hub;

  localparam string CASE_FILE    = "test/spi_hub_cases.txt";
  localparam int    CYCLE_BUDGET = 40;   // watchdog cycles per case
  localparam int    IDLE_LIMIT   = 40;   // idle polls before a transfer counts as hung

  logic                     pclk;
  logic                     SCKclock;
  spi_io_pkg::io_addr_t     io_a_i;
  spi_io_pkg::io_word_t     io_wd_i;
  logic                     io_w_i;
  spi_io_pkg::io_word_t     io_rd_o;
  logic                     flash_cs_o;
  logic                     flash_sck_o;
  spi_line_pkg::lane_t      flash_dq_o;
  spi_line_pkg::lane_t      flash_dq_oe_o;
  spi_line_pkg::lane_t      flash_dq_i;
  logic                     gfx_cs_o;
  logic                     gfx_sck_o;
  spi_line_pkg::lane_t      gfx_dq_o;
  spi_line_pkg::lane_t      gfx_dq_oe_o;
  spi_line_pkg::lane_t      gfx_dq_i;

  string                    case_name [$];
  string                    case_kind [$];
  string                    case_chan [$];
  int                       case_quad [$];
  int                       case_dir [$];
  int                       case_width [$];
  spi_io_pkg::io_word_t     case_tx [$];
  spi_io_pkg::io_word_t     case_manual [$];
  spi_io_pkg::io_word_t     case_exp_word [$];
  spi_line_pkg::spi_pins_t  case_exp_pins [$];
  spi_line_pkg::lane_t      case_exp_oe [$];

  bit                       load_ok;
  bit                       cases_loaded;
  bit                       case_ok;
  int                       pass_count;
  int                       fail_count;
  logic [31:0]              rng_state;

  spi_io_hub dut0 (
    .pclk          (pclk),
    .SCKclock      (SCKclock),
    .io_a_i        (io_a_i),
    .io_wd_i       (io_wd_i),
    .io_w_i        (io_w_i),
    .io_rd_o       (io_rd_o),
    .flash_cs_o    (flash_cs_o),
    .flash_sck_o   (flash_sck_o),
    .flash_dq_o    (flash_dq_o),
    .flash_dq_oe_o (flash_dq_oe_o),
    .flash_dq_i    (flash_dq_i),
    .gfx_cs_o      (gfx_cs_o),
    .gfx_sck_o     (gfx_sck_o),
    .gfx_dq_o      (gfx_dq_o),
    .gfx_dq_oe_o   (gfx_dq_oe_o),
    .gfx_dq_i      (gfx_dq_i)
  );

  // ------------------------------
  // board loopback
  // ------------------------------
  function automatic spi_line_pkg::lane_t loop_lanes(spi_line_pkg::lane_t dq,
                                                     spi_line_pkg::lane_t oe);
    spi_line_pkg::lane_t r;
    r = dq & oe;                                        // undriven lanes read 0
    if (!oe[1] && oe[0]) r[1] = dq[0];                  // single mode, dq0 jumpered to dq1
    return r;
  endfunction

  assign flash_dq_i = loop_lanes(flash_dq_o, flash_dq_oe_o);
  assign gfx_dq_i   = loop_lanes(gfx_dq_o, gfx_dq_oe_o);

  initial begin
    pclk = 1'b0;
    forever #2 pclk = ~pclk;
  end

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int xfer_cycles(bit quad, int width);
    int n;
    n = (width == 8) ? 16 : 32;                         // one pclk per sck phase
    return quad ? n / 4 : n;
  endfunction

  function automatic spi_io_pkg::io_word_t expected_rx(int width, spi_io_pkg::io_word_t tx);
    if (width == 8) return tx;
    else return {tx[7:0], tx[15:8]};                    // bytes come back swapped
  endfunction

  function automatic spi_line_pkg::spi_pins_t expected_idle_pins(bit quad,
      spi_line_pkg::spi_pins_t man, spi_io_pkg::io_word_t rx);
    spi_line_pkg::spi_pins_t p;
    p = man;                                            // engine sck rests low
    if (quad) p.lanes = man.lanes | rx[15:12];
    else p.lanes = man.lanes | {3'b000, rx[15]};
    return p;
  endfunction

  function automatic spi_line_pkg::lane_t expected_oe(bit quad, bit dir);
    return quad ? {4{~dir}} : 4'b1101;
  endfunction

  // ------------------------------
  // bus and pin access
  // ------------------------------
  task automatic bus_write(input spi_io_pkg::io_addr_t a, input spi_io_pkg::io_word_t d);
    @(posedge pclk);
    #1;
    io_a_i  = a;
    io_wd_i = d;
    io_w_i  = 1'b1;
    @(posedge pclk);                                    // write edge
    #1;
    io_w_i  = 1'b0;
  endtask

  task automatic bus_read(input spi_io_pkg::io_addr_t a, output spi_io_pkg::io_word_t d);
    @(posedge pclk);
    #1;
    io_a_i = a;
    io_w_i = 1'b0;
    #1;
    d = io_rd_o;
  endtask

  task automatic setup_channel(input spi_io_pkg::io_addr_t base, input bit quad,
                               input bit dir, input spi_line_pkg::spi_pins_t man);
    bus_write(base + `SPI_OFS_PINS, {10'b0, man});
    bus_write(base + `SPI_OFS_DIR, {15'b0, dir});
    bus_write(base + `SPI_OFS_QUAD, {15'b0, quad});
  endtask

  // called right after the start write, counts edges until idle reads 1
  task automatic wait_idle(input spi_io_pkg::io_addr_t base, output int cycles,
                           output bit done);
    io_a_i = base + `SPI_OFS_IDLE;
    io_w_i = 1'b0;
    #1;
    cycles = 0;
    while (io_rd_o[0] !== 1'b1 && cycles < IDLE_LIMIT) begin
      @(posedge pclk);
      #2;
      cycles++;
    end
    done = (io_rd_o[0] === 1'b1);
  endtask

  task automatic sample_pins(input bit gfx, output spi_line_pkg::spi_pins_t p,
                             output spi_line_pkg::lane_t oe);
    p.cs    = gfx ? gfx_cs_o : flash_cs_o;
    p.sck   = gfx ? gfx_sck_o : flash_sck_o;
    p.lanes = gfx ? gfx_dq_o : flash_dq_o;
    oe      = gfx ? gfx_dq_oe_o : flash_dq_oe_o;
  endtask

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_word(input string name, input spi_io_pkg::io_word_t exp,
                            input spi_io_pkg::io_word_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      case_ok = 1'b0;
    end
  endtask

  task automatic check_pins(input string name, input spi_line_pkg::spi_pins_t exp_p,
                            input spi_line_pkg::lane_t exp_oe,
                            input spi_line_pkg::spi_pins_t act_p,
                            input spi_line_pkg::lane_t act_oe);
    if (act_p !== exp_p) begin
      $display("[ERROR] %s pins: expected %h, actual %h", name, exp_p, act_p);
      case_ok = 1'b0;
    end
    if (act_oe !== exp_oe) begin
      $display("[ERROR] %s oe: expected %h, actual %h", name, exp_oe, act_oe);
      case_ok = 1'b0;
    end
  endtask

  // ------------------------------
  // case handling
  // ------------------------------
  task automatic load_cases();
    int                    fd;
    int                    n;
    string                 line;
    string                 nm;
    string                 kd;
    string                 ch;
    int                    q;
    int                    d;
    int                    w;
    logic [15:0]           tx;
    logic [15:0]           man;
    logic [15:0]           ew;
    logic [15:0]           ep;
    logic [15:0]           eo;
    load_ok = 1'b1;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("could not open the case file %s", CASE_FILE);
      load_ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line[0] != "#") begin
          if ($sscanf(line, "%s %s %s %d %d %d %h %h %h %h %h",
                      nm, kd, ch, q, d, w, tx, man, ew, ep, eo) == 11) begin
            case_name.push_back(nm);
            case_kind.push_back(kd);
            case_chan.push_back(ch);
            case_quad.push_back(q);
            case_dir.push_back(d);
            case_width.push_back(w);
            case_tx.push_back(tx);
            case_manual.push_back(man);
            case_exp_word.push_back(ew);
            case_exp_pins.push_back(spi_line_pkg::spi_pins_t'(ep[5:0]));
            case_exp_oe.push_back(eo[3:0]);
          end else begin
            $display("a line of the case file could not be parsed: %s", line);
            load_ok = 1'b0;
          end
        end
      end
      $fclose(fd);
      if (case_name.size() == 0) begin
        $display("the case file holds no cases");
        load_ok = 1'b0;
      end
    end
    cases_loaded = 1'b1;
  endtask

  task automatic transfer(input string name, input spi_io_pkg::io_addr_t base, input int i,
                          input spi_io_pkg::io_word_t tx, output bit done,
                          output spi_io_pkg::io_word_t rx);
    int                      cycles;
    bit                      quad;
    spi_io_pkg::io_addr_t    start_a;
    quad    = (case_quad[i] != 0);
    start_a = base + ((case_width[i] == 8) ? `SPI_OFS_START8 : `SPI_OFS_START16);
    rx      = '0;
    setup_channel(base, quad, case_dir[i] != 0,
                  spi_line_pkg::spi_pins_t'(case_manual[i][5:0]));
    bus_write(start_a, tx);
    wait_idle(base, cycles, done);
    if (!done) begin
      $display("%s: the transfer never finished, idle stayed low for %0d cycles",
               name, cycles);
      case_ok = 1'b0;
    end else begin
      check_word({name, " cycles"}, spi_io_pkg::io_word_t'(xfer_cycles(quad, case_width[i])),
                 spi_io_pkg::io_word_t'(cycles));
      bus_read(start_a, rx);
    end
  endtask

  task automatic run_case(input int i);
    string                    name;
    string                    kind;
    bit                       gfx;
    bit                       done;
    spi_io_pkg::io_addr_t     base;
    spi_io_pkg::io_addr_t     other;
    spi_io_pkg::io_word_t     rd;
    spi_io_pkg::io_word_t     tx;
    spi_line_pkg::spi_pins_t  man;
    spi_line_pkg::spi_pins_t  pins;
    spi_line_pkg::lane_t      oe;
    name    = case_name[i];
    kind    = case_kind[i];
    gfx     = (case_chan[i] == "gfx");
    base    = gfx ? `SPI_HUB_GFX_BASE : `SPI_HUB_FLASH_BASE;
    other   = gfx ? `SPI_HUB_FLASH_BASE : `SPI_HUB_GFX_BASE;
    man     = spi_line_pkg::spi_pins_t'(case_manual[i][5:0]);
    case_ok = 1'b1;
    if (kind == "rst") begin
      bus_read(base + `SPI_OFS_IDLE, rd);
      check_word({name, " idle"}, case_exp_word[i], rd);
      sample_pins(gfx, pins, oe);
      check_pins(name, case_exp_pins[i], case_exp_oe[i], pins, oe);
    end else if (kind == "pins") begin
      setup_channel(base, case_quad[i] != 0, case_dir[i] != 0, man);
      bus_read(base + `SPI_OFS_PINS, rd);
      check_word({name, " lanes in"}, case_exp_word[i], rd);
      sample_pins(gfx, pins, oe);
      check_pins(name, case_exp_pins[i], case_exp_oe[i], pins, oe);
    end else if (kind == "unmap") begin
      bus_read(case_tx[i][11:0], rd);                   // tx column holds the address
      check_word(name, case_exp_word[i], rd);
      sample_pins(gfx, pins, oe);
      check_pins(name, case_exp_pins[i], case_exp_oe[i], pins, oe);
    end else if (kind == "xfer") begin
      transfer(name, base, i, case_tx[i], done, rd);
      if (done) begin
        check_word({name, " rx"}, case_exp_word[i], rd);
        sample_pins(gfx, pins, oe);
        check_pins(name, case_exp_pins[i], case_exp_oe[i], pins, oe);
      end
    end else if (kind == "rand") begin
      rng_state = lcg_next(rng_state);
      tx = rng_state[31:16];
      transfer(name, base, i, tx, done, rd);
      if (done) begin
        check_word({name, " rx"}, expected_rx(case_width[i], tx), rd);
        sample_pins(gfx, pins, oe);
        check_pins({name, " own"},
                   expected_idle_pins(case_quad[i] != 0, man, expected_rx(case_width[i], tx)),
                   expected_oe(case_quad[i] != 0, case_dir[i] != 0), pins, oe);
        // the other channel must still show its last state
        bus_read(other + `SPI_OFS_IDLE, rd);
        check_word({name, " other idle"}, 16'h0001, rd);
        bus_read(other + `SPI_OFS_START8, rd);
        check_word({name, " other rx"}, case_exp_word[i], rd);
        sample_pins(!gfx, pins, oe);
        check_pins({name, " other"}, case_exp_pins[i], case_exp_oe[i], pins, oe);
      end
    end else begin
      $display("%s: the case kind %s is not known", name, kind);
      case_ok = 1'b0;
    end
    if (case_ok) pass_count++;
    else fail_count++;
    $display("case %-22s %s", name, case_ok ? "ok" : "FAILED");
  endtask

  // ------------------------------
  // watchdog and main run
  // ------------------------------
  initial begin : watchdog
    wait (cases_loaded);
    repeat (case_name.size() * CYCLE_BUDGET + 100) @(posedge pclk);
    $display("watchdog expired, the run took longer than the cases allow");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : run
    SCKclock     = 1'b1;
    io_a_i       = '0;
    io_wd_i      = '0;
    io_w_i       = 1'b0;
    pass_count   = 0;
    fail_count   = 0;
    cases_loaded = 1'b0;
    rng_state    = 32'h37d5;
    load_cases();
    repeat (4) @(posedge pclk);
    #1;
    SCKclock = 1'b0;
    if (load_ok) begin
      for (int i = 0; i < case_name.size(); i++) run_case(i);
    end
    $display("cases passed: %0d, cases failed: %0d", pass_count, fail_count);
    if (load_ok && fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- test/spi_hub_cases.txt
# name kind chan quad dir width tx(hex) manual(hex) exp_word(hex) exp_pins(hex) exp_oe(hex)
# unmap reads tx as the address; rand draws tx and expects the other channel's word and pins
rst_flash           rst   flash 0 0 8  0000 00 0001 00 d
rst_gfx             rst   gfx   0 0 8  0000 00 0001 00 d
pins_flash          pins  flash 0 0 8  0000 2d 000f 2d d
pins_gfx            pins  gfx   0 0 8  0000 16 0004 16 d
pins_flash_quad_in  pins  flash 1 1 8  0000 0f 0000 0f 0
pins_flash_quad_out pins  flash 1 0 8  0000 05 0005 05 f
unmap_high          unmap flash 1 0 8  0120 05 0000 05 f
unmap_offset        unmap flash 1 0 8  0116 05 0000 05 f
sgl8_flash          xfer  flash 0 0 8  a5c3 20 a5c3 21 d
sgl16_flash         xfer  flash 0 0 16 1234 20 3412 20 d
sgl8_gfx            xfer  gfx   0 0 8  8e71 00 8e71 01 d
sgl16_gfx           xfer  gfx   0 0 16 c0de 20 dec0 21 d
quad8_flash         xfer  flash 1 0 8  5af0 20 5af0 25 f
quad16_flash        xfer  flash 1 0 16 9c3b 20 3b9c 23 f
quad8_gfx           xfer  gfx   1 0 8  6d12 00 6d12 06 f
quad16_gfx          xfer  gfx   1 0 16 47e9 00 e947 0e f
pins_gfx_quad_in    pins  gfx   1 1 8  0000 00 0000 0e 0
rand_sgl8           rand  flash 0 0 8  0000 20 e947 0e 0
rand_sgl16          rand  flash 0 0 16 0000 20 e947 0e 0
rand_quad8          rand  flash 1 0 8  0000 20 e947 0e 0
rand_quad16         rand  flash 1 0 16 0000 00 e947 0e 0

//--- spi_io_hub.f
+incdir+src
src/spi_io_pkg.sv
src/spi_line_pkg.sv
src/spi_ctrl_if.sv
src/spi_io_regs.sv
src/spi_channel.sv
src/spi_io_hub.sv
test/tb_spi_io_hub.sv

//--- Bender.yml
package:
  name: spi_io_hub

export_include_dirs:
  - src

sources:
  - src/spi_io_pkg.sv
  - src/spi_line_pkg.sv
  - src/spi_ctrl_if.sv
  - src/spi_io_regs.sv
  - src/spi_channel.sv
  - src/spi_io_hub.sv
  - target: test
    files:
      - test/tb_spi_io_hub.sv
